/* snappy_pkg.sv */
package snappy_pkg;

	localparam int HIST_DEPTH = 4096;	// history window in bytes
	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_AFULL = 12;		// input ready drops at this fill level
	localparam int WORD_BYTES = 8;		// bytes per output beat

	typedef logic [7:0]  byte_t;
	typedef logic [15:0] offset_t;		// copy distance, 1 means newest byte
	typedef logic [11:0] hist_addr_t;
	typedef logic [8:0]  run_len_t;		// literals run up to 256 bytes
	typedef logic [31:0] job_len_t;
	typedef logic [63:0] word_t;
	typedef logic [7:0]  strobe_t;

	// one byte for the history to resolve
	typedef struct packed {
		logic    is_copy;
		byte_t   lit;		// literal byte, unused on copies
		offset_t offset;	// unused on literals
	} byte_op_t;

	typedef struct packed {
		word_t   data;
		strobe_t strobe;
		logic    last;
	} out_beat_t;

	typedef enum logic [1:0] {
		CTRL_IDLE,
		CTRL_RUN,
		CTRL_FLUSH,	// final byte taken, waiting on the last beat
		CTRL_DONE
	} ctrl_state_t;

	typedef enum logic [2:0] {
		PS_TAG,
		PS_LEN,		// extra literal length byte
		PS_OFF_LO,
		PS_OFF_HI,
		PS_LIT,
		PS_COPY
	} parse_state_t;

endpackage

/* input_fifo.sv */
module input_fifo (
	input  logic              clk,
	input  logic              reset_i,
	input  logic              in_valid_i,
	input  snappy_pkg::byte_t in_byte_i,
	output logic              in_ready_o,
	input  logic              pop_i,
	output logic              valid_o,
	output snappy_pkg::byte_t byte_o
);

	snappy_pkg::byte_t mem [snappy_pkg::FIFO_DEPTH];
	logic [$clog2(snappy_pkg::FIFO_DEPTH)-1:0] wr_ptr;
	logic [$clog2(snappy_pkg::FIFO_DEPTH)-1:0] rd_ptr;
	logic [$clog2(snappy_pkg::FIFO_DEPTH):0]   count;
	logic push;

	// early ready drop leaves room for bytes already in flight upstream
	assign in_ready_o = (count < snappy_pkg::FIFO_AFULL);
	assign push       = in_valid_i & in_ready_o;
	assign valid_o    = (count != '0);
	assign byte_o     = mem[rd_ptr];	// show-ahead read

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= in_byte_i;
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;	// pointers wrap, depth is a power of two
			if (pop_i)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop_i})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* token_parser.sv */
module token_parser (
	input  logic                 clk,
	input  logic                 reset_i,
	input  logic                 decode_en_i,
	input  logic                 fifo_valid_i,
	input  snappy_pkg::byte_t    fifo_byte_i,
	output logic                 fifo_pop_o,
	output logic                 op_valid_o,
	output snappy_pkg::byte_op_t op_o,
	input  logic                 op_ready_i
);

	snappy_pkg::parse_state_t state;
	snappy_pkg::run_len_t     run_len;	// bytes left in the current token
	snappy_pkg::offset_t      offset;
	logic long_off;		// two-byte offset copy
	logic rd_ok;
	logic can_issue;

	assign rd_ok     = decode_en_i & fifo_valid_i;
	assign can_issue = !op_valid_o || op_ready_i;	// op slot empty or draining

	always_comb begin
		fifo_pop_o = 1'b0;
		case (state)
			snappy_pkg::PS_TAG,
			snappy_pkg::PS_LEN,
			snappy_pkg::PS_OFF_LO,
			snappy_pkg::PS_OFF_HI: fifo_pop_o = rd_ok;
			snappy_pkg::PS_LIT:    fifo_pop_o = rd_ok & can_issue;
			default:               fifo_pop_o = 1'b0;	// copies read nothing
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state      <= snappy_pkg::PS_TAG;
			run_len    <= '0;
			op_valid_o <= 1'b0;
		end else begin
			if (op_ready_i)
				op_valid_o <= 1'b0;
			case (state)
				snappy_pkg::PS_TAG: begin
					if (rd_ok) begin
						case (fifo_byte_i[1:0])
							2'b00: begin
								run_len <= snappy_pkg::run_len_t'(fifo_byte_i[7:2]) + 9'd1;
								if (fifo_byte_i[7:2] == 6'd60)
									state <= snappy_pkg::PS_LEN;	// length in next byte
								else
									state <= snappy_pkg::PS_LIT;
							end
							2'b01: begin
								run_len <= snappy_pkg::run_len_t'(fifo_byte_i[4:2]) + 9'd4;
								state   <= snappy_pkg::PS_OFF_LO;
							end
							2'b10: begin
								run_len <= snappy_pkg::run_len_t'(fifo_byte_i[7:2]) + 9'd1;
								state   <= snappy_pkg::PS_OFF_LO;
							end
							default: state <= snappy_pkg::PS_TAG;	// 4-byte offsets unsupported
						endcase
					end
				end
				snappy_pkg::PS_LEN: begin
					if (rd_ok) begin
						run_len <= snappy_pkg::run_len_t'(fifo_byte_i) + 9'd1;
						state   <= snappy_pkg::PS_LIT;
					end
				end
				snappy_pkg::PS_OFF_LO: begin
					if (rd_ok)
						state <= long_off ? snappy_pkg::PS_OFF_HI : snappy_pkg::PS_COPY;
				end
				snappy_pkg::PS_OFF_HI: begin
					if (rd_ok)
						state <= snappy_pkg::PS_COPY;
				end
				snappy_pkg::PS_LIT: begin
					if (fifo_pop_o) begin
						op_valid_o <= 1'b1;
						run_len    <= run_len - 9'd1;
						if (run_len == 9'd1)
							state <= snappy_pkg::PS_TAG;
					end
				end
				snappy_pkg::PS_COPY: begin
					if (can_issue) begin
						op_valid_o <= 1'b1;
						run_len    <= run_len - 9'd1;
						if (run_len == 9'd1)
							state <= snappy_pkg::PS_TAG;
					end
				end
				default: state <= snappy_pkg::PS_TAG;
			endcase
		end
	end

	// offset assembly and the op payload
	always_ff @(posedge clk) begin
		if (state == snappy_pkg::PS_TAG && rd_ok) begin
			offset   <= {5'b0, fifo_byte_i[7:5], 8'h00};	// high bits for 1-byte offsets
			long_off <= fifo_byte_i[1];
		end
		if (state == snappy_pkg::PS_OFF_LO && rd_ok)
			offset[7:0] <= fifo_byte_i;
		if (state == snappy_pkg::PS_OFF_HI && rd_ok)
			offset[15:8] <= fifo_byte_i;	// little endian
		if (state == snappy_pkg::PS_LIT && fifo_pop_o) begin
			op_o.is_copy <= 1'b0;
			op_o.lit     <= fifo_byte_i;
			op_o.offset  <= '0;
		end
		if (state == snappy_pkg::PS_COPY && can_issue) begin
			op_o.is_copy <= 1'b1;
			op_o.lit     <= '0;
			op_o.offset  <= offset;		// same distance for the whole run
		end
	end

endmodule

/* history_buffer.sv */
module history_buffer (
	input  logic                 clk,
	input  logic                 reset_i,
	input  logic                 op_valid_i,
	input  snappy_pkg::byte_op_t op_i,
	output logic                 op_ready_o,
	output logic                 byte_valid_o,
	output snappy_pkg::byte_t    byte_o,
	input  logic                 byte_ready_i
);

	snappy_pkg::byte_t hist [snappy_pkg::HIST_DEPTH];
	snappy_pkg::hist_addr_t wr_ptr;		// next free slot
	snappy_pkg::hist_addr_t rd_addr;
	snappy_pkg::byte_t resolved;
	logic accept;

	assign op_ready_o = !byte_valid_o || byte_ready_i;
	assign accept     = op_valid_i && op_ready_o;

	// offset 1 points at the byte written last
	assign rd_addr  = wr_ptr - op_i.offset[11:0];
	assign resolved = op_i.is_copy ? hist[rd_addr] : op_i.lit;

	// each resolved byte lands before the next op reads,
	// so a copy can reach into its own output
	always_ff @(posedge clk) begin
		if (accept) begin
			hist[wr_ptr] <= resolved;
			byte_o       <= resolved;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			wr_ptr       <= '0;
			byte_valid_o <= 1'b0;
		end else begin
			if (accept)
				wr_ptr <= wr_ptr + 1'b1;
			if (accept)
				byte_valid_o <= 1'b1;
			else if (byte_ready_i)
				byte_valid_o <= 1'b0;
		end
	end

endmodule

/* output_packer.sv */
module output_packer (
	input  logic                  clk,
	input  logic                  reset_i,
	input  logic                  byte_valid_i,
	input  snappy_pkg::byte_t     byte_i,
	output logic                  byte_ready_o,
	input  logic                  flush_i,
	output logic                  out_valid_o,
	output snappy_pkg::out_beat_t beat_o,
	input  logic                  out_ready_i,
	output logic                  last_accept_o
);

	snappy_pkg::word_t   data_q;	// word under assembly
	snappy_pkg::strobe_t strb_q;
	snappy_pkg::word_t   fill_data;
	snappy_pkg::strobe_t fill_strb;
	logic [$clog2(snappy_pkg::WORD_BYTES)-1:0] lane;
	logic take;
	logic close;

	// stall while a finished beat is still waiting downstream
	assign byte_ready_o  = !out_valid_o || out_ready_i;
	assign take          = byte_valid_i && byte_ready_o;
	assign close         = take && (lane == snappy_pkg::WORD_BYTES - 1 || flush_i);
	assign last_accept_o = out_valid_o && out_ready_i && beat_o.last;

	always_comb begin
		fill_data = data_q;
		fill_strb = strb_q;
		fill_data[{lane, 3'b000} +: 8] = byte_i;	// lane 0 is the low byte
		fill_strb[lane] = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			lane        <= '0;
			strb_q      <= '0;
			out_valid_o <= 1'b0;
		end else begin
			if (out_ready_i)
				out_valid_o <= 1'b0;
			if (close) begin
				lane        <= '0;
				strb_q      <= '0;
				out_valid_o <= 1'b1;
			end else if (take) begin
				lane   <= lane + 1'b1;
				strb_q <= fill_strb;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take)
			data_q <= fill_data;
		if (close) begin
			beat_o.data   <= fill_data;
			beat_o.strobe <= fill_strb;
			beat_o.last   <= flush_i;	// only the job's final beat is flushed
		end
	end

endmodule

/* decomp_control.sv */
module decomp_control (
	input  logic                 clk,
	input  logic                 reset_i,
	input  logic                 start_i,
	input  snappy_pkg::job_len_t comp_len_i,
	input  snappy_pkg::job_len_t decomp_len_i,
	input  logic                 pop_i,
	input  logic                 byte_accept_i,
	input  logic                 last_accept_i,
	output logic                 decode_en_o,
	output logic                 flush_o,
	output logic                 done_o
);

	snappy_pkg::ctrl_state_t state;
	snappy_pkg::job_len_t comp_left;	// compressed bytes not yet consumed
	snappy_pkg::job_len_t decomp_left;	// output bytes not yet produced

	assign decode_en_o = (state == snappy_pkg::CTRL_RUN) && (comp_left != '0);
	assign flush_o     = (state == snappy_pkg::CTRL_RUN) && byte_accept_i && (decomp_left == 32'd1);
	assign done_o      = (state == snappy_pkg::CTRL_DONE);

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state       <= snappy_pkg::CTRL_IDLE;
			comp_left   <= '0;
			decomp_left <= '0;
		end else begin
			case (state)
				snappy_pkg::CTRL_IDLE: begin
					if (start_i) begin
						comp_left   <= comp_len_i;
						decomp_left <= decomp_len_i;
						state       <= snappy_pkg::CTRL_RUN;
					end
				end
				snappy_pkg::CTRL_RUN: begin
					if (pop_i)
						comp_left <= comp_left - 32'd1;
					if (byte_accept_i)
						decomp_left <= decomp_left - 32'd1;
					if (flush_o)
						state <= snappy_pkg::CTRL_FLUSH;
				end
				snappy_pkg::CTRL_FLUSH: begin
					if (last_accept_i)
						state <= snappy_pkg::CTRL_DONE;
				end
				default: state <= snappy_pkg::CTRL_IDLE;	// done lasts one cycle
			endcase
		end
	end

endmodule

/* decompressor.sv */
module decompressor (
	input  logic                  clk,
	input  logic                  reset_i,
	input  logic                  start_i,
	input  snappy_pkg::job_len_t  comp_len_i,	// compressed bytes in the job
	input  snappy_pkg::job_len_t  decomp_len_i,	// bytes after decoding
	input  logic                  in_valid_i,
	input  snappy_pkg::byte_t     in_byte_i,
	output logic                  in_ready_o,
	output logic                  out_valid_o,
	output snappy_pkg::out_beat_t out_beat_o,
	input  logic                  out_ready_i,
	output logic                  done_o
);

	logic fifo_valid;
	logic fifo_pop;
	snappy_pkg::byte_t fifo_byte;
	logic op_valid;
	logic op_ready;
	snappy_pkg::byte_op_t op;
	logic byte_valid;
	logic byte_ready;
	snappy_pkg::byte_t byte_data;
	logic decode_en;
	logic flush;
	logic last_accept;
	wire  byte_accept = byte_valid & byte_ready;	// one per produced byte

	input_fifo u_fifo (
		.clk        (clk),
		.reset_i    (reset_i),
		.in_valid_i (in_valid_i),
		.in_byte_i  (in_byte_i),
		.in_ready_o (in_ready_o),
		.pop_i      (fifo_pop),
		.valid_o    (fifo_valid),
		.byte_o     (fifo_byte)
	);

	token_parser u_parser (
		.clk          (clk),
		.reset_i      (reset_i),
		.decode_en_i  (decode_en),
		.fifo_valid_i (fifo_valid),
		.fifo_byte_i  (fifo_byte),
		.fifo_pop_o   (fifo_pop),
		.op_valid_o   (op_valid),
		.op_o         (op),
		.op_ready_i   (op_ready)
	);

	history_buffer u_history (
		.clk          (clk),
		.reset_i      (reset_i),
		.op_valid_i   (op_valid),
		.op_i         (op),
		.op_ready_o   (op_ready),
		.byte_valid_o (byte_valid),
		.byte_o       (byte_data),
		.byte_ready_i (byte_ready)
	);

	output_packer u_packer (
		.clk           (clk),
		.reset_i       (reset_i),
		.byte_valid_i  (byte_valid),
		.byte_i        (byte_data),
		.byte_ready_o  (byte_ready),
		.flush_i       (flush),
		.out_valid_o   (out_valid_o),
		.beat_o        (out_beat_o),
		.out_ready_i   (out_ready_i),
		.last_accept_o (last_accept)
	);

	decomp_control u_control (
		.clk           (clk),
		.reset_i       (reset_i),
		.start_i       (start_i),
		.comp_len_i    (comp_len_i),
		.decomp_len_i  (decomp_len_i),
		.pop_i         (fifo_pop),
		.byte_accept_i (byte_accept),
		.last_accept_i (last_accept),
		.decode_en_o   (decode_en),
		.flush_o       (flush),
		.done_o        (done_o)
	);

endmodule

/* tb_snappy_model.svh */
`ifndef TB_SNAPPY_MODEL_SVH
`define TB_SNAPPY_MODEL_SVH

// builds a compressed job in comp_q and the bytes it decodes to in exp_q

function automatic void clear_stream();
	comp_q.delete();
	exp_q.delete();
endfunction

// one byte at a time, so a copy can repeat its own output
function automatic void copy_expected(input int off, input int len);
	int i;
	for (i = 0; i < len; i++)
		exp_q.push_back(exp_q[exp_q.size() - off]);
endfunction

task automatic literal_token(input int len, input bit ext_len);
	int i;
	snappy_pkg::byte_t b;
	if (len > 60 || ext_len) begin
		comp_q.push_back(8'hf0);	// length field 60, one length byte follows
		comp_q.push_back(8'(len - 1));
	end else begin
		comp_q.push_back(8'((len - 1) << 2));
	end
	for (i = 0; i < len; i++) begin
		b = 8'($urandom);
		comp_q.push_back(b);
		exp_q.push_back(b);
	end
endtask

// length 4 to 11, offset below 2048
task automatic short_copy_token(input int off, input int len);
	logic [10:0] o;
	logic [2:0]  l;
	o = 11'(off);
	l = 3'(len - 4);
	comp_q.push_back({o[10:8], l, 2'b01});
	comp_q.push_back(o[7:0]);
	copy_expected(off, len);
endtask

// length 1 to 64, offset in two little endian bytes
task automatic long_copy_token(input int off, input int len);
	logic [15:0] o;
	logic [5:0]  l;
	o = 16'(off);
	l = 6'(len - 1);
	comp_q.push_back({l, 2'b10});
	comp_q.push_back(o[7:0]);
	comp_q.push_back(o[15:8]);
	copy_expected(off, len);
endtask

`endif

/* tb_decompressor.sv */
module tb_decompressor;

	localparam int TIMEOUT_CYCLES = 20000;	// all jobs together need about 5000

	logic clk;
	logic reset_i;
	logic start_i;
	snappy_pkg::job_len_t comp_len_i;
	snappy_pkg::job_len_t decomp_len_i;
	logic in_valid_i;
	snappy_pkg::byte_t in_byte_i;
	logic in_ready_o;
	logic out_valid_o;
	snappy_pkg::out_beat_t out_beat_o;
	logic out_ready_i;
	logic done_o;

	snappy_pkg::byte_t comp_q[$];	// compressed job
	snappy_pkg::byte_t exp_q[$];
	snappy_pkg::byte_t got_q[$];	// bytes the DUT produced
	int errors;
	int checks;
	int beats;
	snappy_pkg::strobe_t last_strobe;
	bit saw_in_stall;		// in_ready low during an output stall

	`include "tb_snappy_model.svh"

	decompressor u_dut (
		.clk          (clk),
		.reset_i      (reset_i),
		.start_i      (start_i),
		.comp_len_i   (comp_len_i),
		.decomp_len_i (decomp_len_i),
		.in_valid_i   (in_valid_i),
		.in_byte_i    (in_byte_i),
		.in_ready_o   (in_ready_o),
		.out_valid_o  (out_valid_o),
		.out_beat_o   (out_beat_o),
		.out_ready_i  (out_ready_i),
		.done_o       (done_o)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("simulation timed out after %0d cycles", cycles);
		$display("Test failures found");
		$finish;
	end

	task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s, got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic check_beat(input snappy_pkg::out_beat_t beat, inout int pos);
		int left;
		int k;
		int i;
		left = exp_q.size() - pos;
		k = (left < snappy_pkg::WORD_BYTES) ? left : snappy_pkg::WORD_BYTES;
		// lanes fill from 0 up, only the final beat may be short
		check_eq(beat.strobe, (64'd1 << k) - 1, "beat strobe");
		check_eq(beat.last, left <= snappy_pkg::WORD_BYTES, "beat last flag");
		for (i = 0; i < k; i++) begin
			check_eq(beat.data[i*8 +: 8], exp_q[pos + i], $sformatf("output byte %0d", pos + i));
			got_q.push_back(beat.data[i*8 +: 8]);
		end
		pos += k;
		beats++;
		last_strobe = beat.strobe;
	endtask

	task automatic feed_input(input bit stalls);
		int idx;
		idx = 0;
		while (idx < comp_q.size()) begin
			@(negedge clk);
			in_valid_i = !(stalls && $urandom % 4 == 0);	// random gaps
			in_byte_i  = comp_q[idx];
			if (in_valid_i && in_ready_o)
				idx++;		// taken at the next rising edge
		end
		@(negedge clk);
		in_valid_i = 1'b0;
	endtask

	task automatic collect_output(input bit stalls);
		int pos;
		int stall_left;
		bit got_last;
		pos        = 0;
		stall_left = 0;
		got_last   = 1'b0;
		while (!got_last) begin
			@(negedge clk);
			if (stalls && stall_left == 0 && $urandom % 16 == 0)
				stall_left = 32 + $urandom % 32;
			out_ready_i = (stall_left == 0);
			if (stall_left > 0) begin
				stall_left--;
				if (!in_ready_o)
					saw_in_stall = 1'b1;
			end
			check_eq(done_o, 0, "done_o before the last beat");
			if (out_valid_o && out_ready_i) begin
				check_beat(out_beat_o, pos);
				got_last = out_beat_o.last || pos >= exp_q.size();
			end
		end
		@(negedge clk);
		check_eq(done_o, 1, "done_o one cycle after the last beat");
		@(negedge clk);
		check_eq(done_o, 0, "done_o pulse length");
	endtask

	task automatic run_job(input bit stalls);
		got_q.delete();
		beats = 0;
		@(negedge clk);
		start_i      = 1'b1;
		comp_len_i   = comp_q.size();
		decomp_len_i = exp_q.size();
		@(negedge clk);
		start_i = 1'b0;
		fork
			feed_input(stalls);
			collect_output(stalls);
		join
	endtask

	task automatic literals_only();
		clear_stream();
		literal_token(4, 1'b0);
		literal_token(16, 1'b1);	// length in the extra byte
		literal_token(4, 1'b0);
		run_job(1'b0);
		check_eq(beats, 3, "beat count of the literal job");
	endtask

	task automatic overlapping_copy();
		clear_stream();
		literal_token(3, 1'b0);
		short_copy_token(1, 8);		// repeats the newest byte
		short_copy_token(3, 6);
		long_copy_token(2, 5);
		run_job(1'b0);
	endtask

	task automatic far_window_copy();
		int i;
		clear_stream();
		for (i = 0; i < 10; i++)
			literal_token(250, 1'b0);
		long_copy_token(2300, 40);
		long_copy_token(2499, 64);	// back near the first byte of the job
		run_job(1'b0);
	endtask

	task automatic stalled_stream();
		snappy_pkg::byte_t ref_q[$];
		int i;
		clear_stream();
		literal_token(70, 1'b0);
		short_copy_token(5, 11);
		literal_token(120, 1'b0);
		long_copy_token(150, 64);
		literal_token(61, 1'b0);
		short_copy_token(200, 7);
		literal_token(40, 1'b0);
		run_job(1'b0);
		ref_q = got_q;
		saw_in_stall = 1'b0;
		run_job(1'b1);
		check_eq(got_q.size(), ref_q.size(), "byte count with stalls");
		for (i = 0; i < ref_q.size() && i < got_q.size(); i++)
			check_eq(got_q[i], ref_q[i], $sformatf("stalled byte %0d", i));
		if (!saw_in_stall) begin
			errors++;
			$display("in_ready_o never dropped while out_ready_i was held low");
		end
	endtask

	task automatic short_job_restart();
		clear_stream();
		literal_token(13, 1'b0);
		run_job(1'b0);
		check_eq(beats, 2, "beat count of the 13 byte job");
		check_eq(last_strobe, 8'h1f, "final strobe covers lanes 0 to 4");
		clear_stream();
		literal_token(6, 1'b0);
		short_copy_token(2, 9);
		run_job(1'b0);
	endtask

	initial begin
		void'($urandom(35879));
		errors       = 0;
		checks       = 0;
		reset_i      = 1'b1;
		start_i      = 1'b0;
		comp_len_i   = '0;
		decomp_len_i = '0;
		in_valid_i   = 1'b0;
		in_byte_i    = '0;
		out_ready_i  = 1'b0;
		repeat (4) @(negedge clk);
		reset_i = 1'b0;
		check_eq(in_ready_o, 1, "in_ready_o after reset");
		check_eq(out_valid_o, 0, "out_valid_o after reset");
		check_eq(done_o, 0, "done_o after reset");
		literals_only();
		overlapping_copy();
		far_window_copy();
		stalled_stream();
		short_job_restart();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

/* compile.f */
+incdir+.
snappy_pkg.sv
input_fifo.sv
token_parser.sv
history_buffer.sv
output_packer.sv
decomp_control.sv
decompressor.sv
tb_decompressor.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_decompressor -o sim_tb
out="$(./obj_dir/sim_tb)"
echo "$out"

if echo "$out" | grep -qF "All tests passed!"; then
	exit 0
fi
exit 1
